// File: Bender.yml
package:
  name: decode_execute

sources:
  - src/CorePkg.sv
  - src/DecodeUnit.sv
  - src/RegisterFile.sv
  - src/DEReg.sv
  - src/ExecuteUnit.sv
  - src/DecodeExecuteTop.sv
  - target: test
    files:
      - test/DecodeExecuteTb.sv

// File: filelist.f
src/CorePkg.sv
src/DecodeUnit.sv
src/RegisterFile.sv
src/DEReg.sv
src/ExecuteUnit.sv
src/DecodeExecuteTop.sv
test/DecodeExecuteTb.sv

// File: src/CorePkg.sv
`default_nettype none

package CorePkg;

    typedef logic [31:0] wordT;
    typedef logic [3:0] regAddrT;
    typedef logic [3:0] condT;
    typedef logic [3:0] flagsT; // N, Z, C, V from MSB to LSB
    typedef logic [3:0] aluCtrlT;
    typedef logic [1:0] shiftT;
    typedef logic [4:0] shamtT;

    localparam int NumRegs = 16;

    // ALU codes follow the ARM data-processing opcodes
    localparam aluCtrlT AluAnd = 4'b0000;
    localparam aluCtrlT AluEor = 4'b0001;
    localparam aluCtrlT AluSub = 4'b0010;
    localparam aluCtrlT AluRsb = 4'b0011;
    localparam aluCtrlT AluAdd = 4'b0100;
    localparam aluCtrlT AluAdc = 4'b0101;
    localparam aluCtrlT AluOrr = 4'b1100;
    localparam aluCtrlT AluMov = 4'b1101;
    localparam aluCtrlT AluBic = 4'b1110;

    localparam shiftT ShLsl = 2'b00;
    localparam shiftT ShLsr = 2'b01;
    localparam shiftT ShAsr = 2'b10;
    localparam shiftT ShRor = 2'b11;

    localparam condT CondEq = 4'b0000;
    localparam condT CondNe = 4'b0001;
    localparam condT CondCs = 4'b0010;
    localparam condT CondCc = 4'b0011;
    localparam condT CondMi = 4'b0100;
    localparam condT CondPl = 4'b0101;
    localparam condT CondVs = 4'b0110;
    localparam condT CondVc = 4'b0111;
    localparam condT CondHi = 4'b1000;
    localparam condT CondLs = 4'b1001;
    localparam condT CondGe = 4'b1010;
    localparam condT CondLt = 4'b1011;
    localparam condT CondGt = 4'b1100;
    localparam condT CondLe = 4'b1101;
    localparam condT CondAl = 4'b1110;

endpackage

`default_nettype wire

// File: src/DEReg.sv
`timescale 1ns/1ps
`default_nettype none

module DEReg (
    input wire CLK,
    input wire Reset,
    input wire EN,
    input wire CLR,
    input wire CorePkg::regAddrT RA1D,
    input wire CorePkg::regAddrT RA2D,
    input wire CorePkg::condT CondD,
    input wire CorePkg::flagsT FlagWD,
    input wire RegWD,
    input wire NoWriteD,
    input wire CorePkg::regAddrT WA3D,
    input wire ALUSrcD,
    input wire CorePkg::aluCtrlT ALUControlD,
    input wire CorePkg::wordT RD1D,
    input wire CorePkg::wordT RD2D,
    input wire CorePkg::wordT ExtImmD,
    input wire CorePkg::shiftT ShD,
    input wire CorePkg::shamtT Shamt5D,
    output CorePkg::regAddrT RA1E,
    output CorePkg::regAddrT RA2E,
    output CorePkg::condT CondE,
    output CorePkg::flagsT FlagWE,
    output logic RegWE,
    output logic NoWriteE,
    output CorePkg::regAddrT WA3E,
    output logic ALUSrcE,
    output CorePkg::aluCtrlT ALUControlE,
    output CorePkg::wordT RD1E,
    output CorePkg::wordT RD2E,
    output CorePkg::wordT ExtImmE,
    output CorePkg::shiftT ShE,
    output CorePkg::shamtT Shamt5E
);

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            {RA1E, RA2E, CondE, FlagWE, RegWE, NoWriteE, WA3E} <= '0;
            {ALUSrcE, ALUControlE, RD1E, RD2E, ExtImmE, ShE, Shamt5E} <= '0;
        end else if (CLR) begin
            // Flushed slot becomes a bubble with no register or flag write
            {RA1E, RA2E, CondE, FlagWE, RegWE, NoWriteE, WA3E} <= '0;
            {ALUSrcE, ALUControlE, RD1E, RD2E, ExtImmE, ShE, Shamt5E} <= '0;
        end else if (EN) begin
            RA1E <= RA1D;
            RA2E <= RA2D;
            CondE <= CondD;
            FlagWE <= FlagWD;
            RegWE <= RegWD;
            NoWriteE <= NoWriteD;
            WA3E <= WA3D;
            ALUSrcE <= ALUSrcD;
            ALUControlE <= ALUControlD;
            RD1E <= RD1D;
            RD2E <= RD2D;
            ExtImmE <= ExtImmD;
            ShE <= ShD;
            Shamt5E <= Shamt5D;
        end
    end

    clrMakesBubble: assert property (@(posedge CLK) disable iff (Reset)
        CLR |=> (!RegWE && FlagWE == '0))
        else $error("DEReg clear did not produce a bubble");

endmodule

`default_nettype wire

// File: src/DecodeExecuteTop.sv
`timescale 1ns/1ps
`default_nettype none

module DecodeExecuteTop (
    input wire CLK,
    input wire Reset,
    input wire CorePkg::wordT Instr,
    input wire InstrValid,
    input wire Stall,
    input wire Flush,
    output wire CorePkg::wordT ResultW,
    output wire CorePkg::regAddrT WA3W,
    output wire RegWriteW,
    output wire CorePkg::flagsT Flags
);
    import CorePkg::*;

    regAddrT RA1D, RA2D, WA3D;
    condT CondD;
    flagsT FlagWD;
    logic RegWD, NoWriteD, ALUSrcD;
    aluCtrlT ALUControlD;
    wordT ExtImmD, RD1D, RD2D;
    shiftT ShD;
    shamtT Shamt5D;

    regAddrT RA1E, RA2E, WA3E;
    condT CondE;
    flagsT FlagWE;
    logic RegWE, NoWriteE, ALUSrcE;
    aluCtrlT ALUControlE;
    wordT ExtImmE, RD1E, RD2E;
    shiftT ShE;
    shamtT Shamt5E;

    wire deEnable;

    assign deEnable = ~Stall; // A stall holds the decode-to-execute register

    DecodeUnit decode_i (
        .Instr(Instr), .InstrValid(InstrValid),
        .RA1D(RA1D), .RA2D(RA2D), .WA3D(WA3D), .CondD(CondD), .FlagWD(FlagWD),
        .RegWD(RegWD), .NoWriteD(NoWriteD), .ALUSrcD(ALUSrcD), .ALUControlD(ALUControlD),
        .ExtImmD(ExtImmD), .ShD(ShD), .Shamt5D(Shamt5D)
    );

    RegisterFile regFile_i (
        .CLK(CLK), .Reset(Reset), .RA1(RA1D), .RA2(RA2D), .WA3(WA3W),
        .WE(RegWriteW), .WD(ResultW), .RD1(RD1D), .RD2(RD2D)
    );

    DEReg deReg_i (
        .CLK(CLK), .Reset(Reset), .EN(deEnable), .CLR(Flush),
        .RA1D(RA1D), .RA2D(RA2D), .CondD(CondD), .FlagWD(FlagWD), .RegWD(RegWD),
        .NoWriteD(NoWriteD), .WA3D(WA3D), .ALUSrcD(ALUSrcD), .ALUControlD(ALUControlD),
        .RD1D(RD1D), .RD2D(RD2D), .ExtImmD(ExtImmD), .ShD(ShD), .Shamt5D(Shamt5D),
        .RA1E(RA1E), .RA2E(RA2E), .CondE(CondE), .FlagWE(FlagWE), .RegWE(RegWE),
        .NoWriteE(NoWriteE), .WA3E(WA3E), .ALUSrcE(ALUSrcE), .ALUControlE(ALUControlE),
        .RD1E(RD1E), .RD2E(RD2E), .ExtImmE(ExtImmE), .ShE(ShE), .Shamt5E(Shamt5E)
    );

    ExecuteUnit execute_i (
        .CLK(CLK), .Reset(Reset),
        .RA1E(RA1E), .RA2E(RA2E), .CondE(CondE), .FlagWE(FlagWE), .RegWE(RegWE),
        .NoWriteE(NoWriteE), .WA3E(WA3E), .ALUSrcE(ALUSrcE), .ALUControlE(ALUControlE),
        .RD1E(RD1E), .RD2E(RD2E), .ExtImmE(ExtImmE), .ShE(ShE), .Shamt5E(Shamt5E),
        .ResultW(ResultW), .WA3W(WA3W), .RegWriteW(RegWriteW), .Flags(Flags)
    );

endmodule

`default_nettype wire

// File: src/DecodeUnit.sv
`timescale 1ns/1ps
`default_nettype none

module DecodeUnit (
    input wire CorePkg::wordT Instr,
    input wire InstrValid,
    output CorePkg::regAddrT RA1D,
    output CorePkg::regAddrT RA2D,
    output CorePkg::regAddrT WA3D,
    output CorePkg::condT CondD,
    output CorePkg::flagsT FlagWD,
    output logic RegWD,
    output logic NoWriteD,
    output logic ALUSrcD,
    output CorePkg::aluCtrlT ALUControlD,
    output CorePkg::wordT ExtImmD,
    output CorePkg::shiftT ShD,
    output CorePkg::shamtT Shamt5D
);
    import CorePkg::*;

    logic [3:0] opcode;
    logic setFlags;
    logic isArith;
    logic isTest;
    logic supported;
    logic regShift;
    logic valid;
    logic [4:0] rotAmt;
    logic [63:0] immWide;
    logic [63:0] immRotated;

    assign opcode = Instr[24:21];
    assign setFlags = Instr[20];
    assign regShift = !Instr[25] && Instr[4]; // Shift by a register is not supported

    assign RA1D = Instr[19:16];
    assign WA3D = Instr[15:12];
    assign RA2D = Instr[3:0];
    assign ALUSrcD = Instr[25];
    assign ShD = Instr[6:5];
    assign Shamt5D = Instr[11:7];

    // Rotating a doubled copy right gives the wrap-around for free
    assign rotAmt = {Instr[11:8], 1'b0};
    assign immWide = {24'b0, Instr[7:0], 24'b0, Instr[7:0]};
    assign immRotated = immWide >> rotAmt;
    assign ExtImmD = immRotated[31:0];

    always_comb begin
        ALUControlD = AluAnd;
        isArith = 1'b0;
        isTest = 1'b0;
        supported = 1'b1;
        case (opcode)
            4'b0000: ALUControlD = AluAnd;
            4'b0001: ALUControlD = AluEor;
            4'b0010: begin
                ALUControlD = AluSub;
                isArith = 1'b1;
            end
            4'b0011: begin
                ALUControlD = AluRsb;
                isArith = 1'b1;
            end
            4'b0100: begin
                ALUControlD = AluAdd;
                isArith = 1'b1;
            end
            4'b0101: begin
                ALUControlD = AluAdc;
                isArith = 1'b1;
            end
            4'b1000: begin
                ALUControlD = AluAnd; // TST
                isTest = 1'b1;
            end
            4'b1001: begin
                ALUControlD = AluEor; // TEQ
                isTest = 1'b1;
            end
            4'b1010: begin
                ALUControlD = AluSub; // CMP
                isTest = 1'b1;
                isArith = 1'b1;
            end
            4'b1011: begin
                ALUControlD = AluAdd; // CMN
                isTest = 1'b1;
                isArith = 1'b1;
            end
            4'b1100: ALUControlD = AluOrr;
            4'b1101: ALUControlD = AluMov;
            4'b1110: ALUControlD = AluBic;
            default: supported = 1'b0; // SBC, RSC and MVN fall outside the subset
        endcase
    end

    assign valid = InstrValid && Instr[27:26] == 2'b00 && !regShift && supported;

    assign RegWD = valid && !isTest;
    assign NoWriteD = valid && isTest;
    assign CondD = valid ? Instr[31:28] : CondAl;
    assign FlagWD = (valid && (setFlags || isTest)) ? (isArith ? 4'b1111 : 4'b1100) : 4'b0000;

endmodule

`default_nettype wire

// File: src/ExecuteUnit.sv
`timescale 1ns/1ps
`default_nettype none

module ExecuteUnit (
    input wire CLK,
    input wire Reset,
    input wire CorePkg::regAddrT RA1E,
    input wire CorePkg::regAddrT RA2E,
    input wire CorePkg::condT CondE,
    input wire CorePkg::flagsT FlagWE,
    input wire RegWE,
    input wire NoWriteE,
    input wire CorePkg::regAddrT WA3E,
    input wire ALUSrcE,
    input wire CorePkg::aluCtrlT ALUControlE,
    input wire CorePkg::wordT RD1E,
    input wire CorePkg::wordT RD2E,
    input wire CorePkg::wordT ExtImmE,
    input wire CorePkg::shiftT ShE,
    input wire CorePkg::shamtT Shamt5E,
    output CorePkg::wordT ResultW,
    output CorePkg::regAddrT WA3W,
    output logic RegWriteW,
    output CorePkg::flagsT Flags
);
    import CorePkg::*;

    wordT srcA;
    wordT srcBReg;
    wordT shiftedB;
    wordT srcB;
    wordT addA;
    wordT addB;
    wordT aluResult;
    logic [63:0] rorWide;
    logic [32:0] sum;
    logic carryIn;
    logic overflow;
    logic flagN, flagZ, flagC, flagV;
    flagsT aluFlags;
    logic condEx;

    assign {flagN, flagZ, flagC, flagV} = Flags;

    // Forward the value still waiting in the writeback register
    assign srcA = (RegWriteW && RA1E == WA3W) ? ResultW : RD1E;
    assign srcBReg = (RegWriteW && RA2E == WA3W) ? ResultW : RD2E;

    assign rorWide = {srcBReg, srcBReg} >> Shamt5E;

    always_comb begin
        case (ShE)
            ShLsl: shiftedB = srcBReg << Shamt5E;
            ShLsr: shiftedB = (Shamt5E == '0) ? '0 : srcBReg >> Shamt5E; // Zero encodes 32
            ShAsr: shiftedB = (Shamt5E == '0) ? {32{srcBReg[31]}}
                                              : wordT'($signed(srcBReg) >>> Shamt5E);
            ShRor: shiftedB = rorWide[31:0];
            default: shiftedB = srcBReg;
        endcase
    end

    assign srcB = ALUSrcE ? ExtImmE : shiftedB;

    // Subtraction is done as A + ~B + 1 so C is the ARM not-borrow
    always_comb begin
        addA = srcA;
        addB = srcB;
        carryIn = 1'b0;
        case (ALUControlE)
            AluAdc: carryIn = flagC;
            AluSub: begin
                addB = ~srcB;
                carryIn = 1'b1;
            end
            AluRsb: begin
                addA = srcB;
                addB = ~srcA;
                carryIn = 1'b1;
            end
            default: carryIn = 1'b0;
        endcase
    end

    assign sum = {1'b0, addA} + {1'b0, addB} + {32'b0, carryIn};
    assign overflow = (addA[31] == addB[31]) && (sum[31] != addA[31]);

    always_comb begin
        case (ALUControlE)
            AluAnd: aluResult = srcA & srcB;
            AluEor: aluResult = srcA ^ srcB;
            AluOrr: aluResult = srcA | srcB;
            AluMov: aluResult = srcB;
            AluBic: aluResult = srcA & ~srcB;
            AluSub, AluRsb, AluAdd, AluAdc: aluResult = sum[31:0];
            default: aluResult = '0;
        endcase
    end

    assign aluFlags = {aluResult[31], aluResult == '0, sum[32], overflow};

    always_comb begin
        case (CondE)
            CondEq: condEx = flagZ;
            CondNe: condEx = !flagZ;
            CondCs: condEx = flagC;
            CondCc: condEx = !flagC;
            CondMi: condEx = flagN;
            CondPl: condEx = !flagN;
            CondVs: condEx = flagV;
            CondVc: condEx = !flagV;
            CondHi: condEx = flagC && !flagZ;
            CondLs: condEx = !flagC || flagZ;
            CondGe: condEx = flagN == flagV;
            CondLt: condEx = flagN != flagV;
            CondGt: condEx = !flagZ && flagN == flagV;
            CondLe: condEx = flagZ || flagN != flagV;
            CondAl: condEx = 1'b1;
            default: condEx = 1'b0;
        endcase
    end

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            Flags <= '0;
            WA3W <= '0;
            RegWriteW <= 1'b0;
        end else begin
            if (condEx) begin
                Flags <= (Flags & ~FlagWE) | (aluFlags & FlagWE); // Only the masked flags change
            end
            WA3W <= WA3E;
            RegWriteW <= RegWE && condEx && !NoWriteE;
        end
    end

    always_ff @(posedge CLK) begin
        ResultW <= aluResult;
    end

    writeNeedsCond: assert property (@(posedge CLK) disable iff (Reset)
        RegWriteW |-> $past(condEx))
        else $error("Register write without a passing condition");

endmodule

`default_nettype wire

// File: src/RegisterFile.sv
`timescale 1ns/1ps
`default_nettype none

module RegisterFile (
    input wire CLK,
    input wire Reset,
    input wire CorePkg::regAddrT RA1,
    input wire CorePkg::regAddrT RA2,
    input wire CorePkg::regAddrT WA3,
    input wire WE,
    input wire CorePkg::wordT WD,
    output CorePkg::wordT RD1,
    output CorePkg::wordT RD2
);
    import CorePkg::*;

    wordT regs [NumRegs];

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (WE) begin
            regs[WA3] <= WD;
        end
    end

    // A read of the register being written sees the new value in the same cycle
    assign RD1 = (WE && WA3 == RA1) ? WD : regs[RA1];
    assign RD2 = (WE && WA3 == RA2) ? WD : regs[RA2];

    weKnown: assert property (@(posedge CLK) disable iff (Reset) !$isunknown(WE))
        else $error("RegisterFile write enable is unknown");

endmodule

`default_nettype wire

// File: test/DecodeExecuteTb.sv
`timescale 1ns/1ps
`default_nettype none

module DecodeExecuteTb;
    import CorePkg::*;

    localparam int ClkPeriod = 100;
    localparam int WriteTimeout = 10;
    localparam int WatchdogCycles = 2000;

    localparam logic [3:0] OpAnd = 4'd0;
    localparam logic [3:0] OpEor = 4'd1;
    localparam logic [3:0] OpSub = 4'd2;
    localparam logic [3:0] OpRsb = 4'd3;
    localparam logic [3:0] OpAdd = 4'd4;
    localparam logic [3:0] OpAdc = 4'd5;
    localparam logic [3:0] OpTst = 4'd8;
    localparam logic [3:0] OpTeq = 4'd9;
    localparam logic [3:0] OpCmp = 4'd10;
    localparam logic [3:0] OpCmn = 4'd11;
    localparam logic [3:0] OpOrr = 4'd12;
    localparam logic [3:0] OpMov = 4'd13;
    localparam logic [3:0] OpBic = 4'd14;

    logic CLK;
    logic Reset;
    wordT Instr;
    logic InstrValid;
    logic Stall;
    logic Flush;
    wordT ResultW;
    regAddrT WA3W;
    logic RegWriteW;
    flagsT Flags;

    wordT modelRegs [16];
    flagsT modelFlags;
    wordT captured; // Word that the DEReg holds after the current edge
    logic capturedValid;
    wordT expInstr [$];
    logic expWr [$];
    wordT expRes [$];
    regAddrT expWa [$];
    flagsT expFlags [$];
    int errorCount;
    int checkCount;
    integer seed;

    DecodeExecuteTop dut_i (
        .CLK(CLK), .Reset(Reset), .Instr(Instr), .InstrValid(InstrValid),
        .Stall(Stall), .Flush(Flush), .ResultW(ResultW), .WA3W(WA3W),
        .RegWriteW(RegWriteW), .Flags(Flags)
    );

    initial begin
        CLK = 1'b0;
        forever #(ClkPeriod / 2) CLK = ~CLK;
    end

    function automatic wordT encImm(condT cond, logic [3:0] op, logic s, regAddrT rn,
                                    regAddrT rd, logic [3:0] rot, logic [7:0] imm);
        return {cond, 2'b00, 1'b1, op, s, rn, rd, rot, imm};
    endfunction

    function automatic wordT encReg(condT cond, logic [3:0] op, logic s, regAddrT rn,
                                    regAddrT rd, shamtT amt, shiftT sh, regAddrT rm);
        return {cond, 2'b00, 1'b0, op, s, rn, rd, amt, sh, 1'b0, rm};
    endfunction

    function automatic logic condPasses(condT cond, flagsT f);
        logic n, z, c, v;
        {n, z, c, v} = f;
        case (cond)
            4'h0: return z;
            4'h1: return !z;
            4'h2: return c;
            4'h3: return !c;
            4'h4: return n;
            4'h5: return !n;
            4'h6: return v;
            4'h7: return !v;
            4'h8: return c && !z;
            4'h9: return !c || z;
            4'hA: return n == v;
            4'hB: return n != v;
            4'hC: return !z && n == v;
            4'hD: return z || n != v;
            4'hE: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic wordT operand2(wordT instr, wordT rm);
        int amt;
        int rot;
        wordT imm;
        imm = {24'b0, instr[7:0]};
        rot = 2 * instr[11:8];
        amt = instr[11:7];
        if (instr[25]) begin
            return (rot == 0) ? imm : (imm >> rot) | (imm << (32 - rot));
        end
        case (instr[6:5])
            2'b00: return rm << amt;
            2'b01: return (amt == 0) ? 32'h0 : rm >> amt; // LSR #0 means 32
            2'b10: return (amt == 0) ? {32{rm[31]}} : wordT'($signed(rm) >>> amt);
            default: return (amt == 0) ? rm : (rm >> amt) | (rm << (32 - amt));
        endcase
    endfunction

    // Executes one word on the register and flag model in program order
    task automatic modelExec(input wordT instr, input logic valid, output logic wr,
                             output wordT res, output regAddrT wa);
        logic [3:0] op;
        logic isTest;
        logic isArith;
        logic known;
        wordT a;
        wordT b;
        logic [32:0] wide;
        logic c;
        logic v;
        op = instr[24:21];
        isTest = op[3:2] == 2'b10;
        isArith = (op >= OpSub && op <= OpAdc) || op == OpCmp || op == OpCmn;
        known = valid && instr[27:26] == 2'b00 && !(!instr[25] && instr[4])
                && op != 4'd6 && op != 4'd7 && op != 4'd15;
        wr = 1'b0;
        wa = instr[15:12];
        res = '0;
        if (known && condPasses(instr[31:28], modelFlags)) begin
            a = modelRegs[instr[19:16]];
            b = operand2(instr, modelRegs[instr[3:0]]);
            c = modelFlags[1];
            v = modelFlags[0];
            case (op)
                OpAnd, OpTst: res = a & b;
                OpEor, OpTeq: res = a ^ b;
                OpOrr: res = a | b;
                OpMov: res = b;
                OpBic: res = a & ~b;
                OpSub, OpCmp: begin
                    res = a - b;
                    c = a >= b;
                    v = (a[31] != b[31]) && (res[31] != a[31]);
                end
                OpRsb: begin
                    res = b - a;
                    c = b >= a;
                    v = (a[31] != b[31]) && (res[31] != b[31]);
                end
                default: begin
                    wide = {1'b0, a} + {1'b0, b} + {32'b0, op == OpAdc && modelFlags[1]};
                    res = wide[31:0];
                    c = wide[32];
                    v = (a[31] == b[31]) && (res[31] != a[31]);
                end
            endcase
            if (instr[20] || isTest) begin
                modelFlags[3:2] = {res[31], res == '0};
                if (isArith) begin
                    modelFlags[1:0] = {c, v};
                end
            end
            if (!isTest) begin
                modelRegs[wa] = res;
                wr = 1'b1;
            end
        end
    endtask

    task automatic checkWriteback();
        wordT instr;
        logic wr;
        wordT res;
        regAddrT wa;
        flagsT fl;
        instr = expInstr.pop_front();
        wr = expWr.pop_front();
        res = expRes.pop_front();
        wa = expWa.pop_front();
        fl = expFlags.pop_front();
        checkCount++;
        if (RegWriteW !== wr) begin
            errorCount++;
            $display("ERROR at %0t: %h gave RegWriteW %b, expected %b", $time, instr,
                     RegWriteW, wr);
        end else if (wr && (ResultW !== res || WA3W !== wa)) begin
            errorCount++;
            $display("ERROR at %0t: %h wrote %h to R%0d, expected %h to R%0d", $time, instr,
                     ResultW, WA3W, res, wa);
        end
        if (Flags !== fl) begin
            errorCount++;
            $display("ERROR at %0t: %h left Flags %b, expected %b", $time, instr, Flags, fl);
        end
    endtask

    // One clock: check the word that reached writeback, then drive the next one
    task automatic runCycle(input wordT instr, input logic valid, input logic stall,
                            input logic flush);
        logic wr;
        wordT res;
        regAddrT wa;
        @(posedge CLK);
        #1;
        if (expWr.size() == 2) begin
            checkWriteback();
        end
        Instr = instr;
        InstrValid = valid;
        Stall = stall;
        Flush = flush;
        if (flush) begin
            capturedValid = 1'b0;
        end else if (!stall) begin
            captured = instr;
            capturedValid = valid;
        end
        modelExec(captured, capturedValid, wr, res, wa); // A stalled word executes again
        expInstr.push_back(captured);
        expWr.push_back(wr);
        expRes.push_back(res);
        expWa.push_back(wa);
        expFlags.push_back(modelFlags);
    endtask

    task automatic idleCycles(input int count);
        repeat (count) runCycle('0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic waitForWrite();
        int count;
        count = 0;
        while (RegWriteW !== 1'b1 && count < WriteTimeout) begin
            runCycle('0, 1'b0, 1'b0, 1'b0);
            count++;
        end
        if (RegWriteW !== 1'b1) begin
            errorCount++;
            $display("No register write appeared within %0d cycles", WriteTimeout);
        end
    endtask

    task automatic loadRegister(input regAddrT rd, input wordT value);
        runCycle(encImm(CondAl, OpMov, 1'b0, 0, rd, 4, value[31:24]), 1'b1, 1'b0, 1'b0);
        runCycle(encImm(CondAl, OpOrr, 1'b0, rd, rd, 8, value[23:16]), 1'b1, 1'b0, 1'b0);
        runCycle(encImm(CondAl, OpOrr, 1'b0, rd, rd, 12, value[15:8]), 1'b1, 1'b0, 1'b0);
        runCycle(encImm(CondAl, OpOrr, 1'b0, rd, rd, 0, value[7:0]), 1'b1, 1'b0, 1'b0);
    endtask

    task automatic resetBehavior();
        checkCount++;
        if (RegWriteW !== 1'b0 || Flags !== 4'b0000) begin
            errorCount++;
            $display("ERROR at %0t: after reset RegWriteW %b Flags %b, expected 0 and 0000",
                     $time, RegWriteW, Flags);
        end
        runCycle(encReg(CondAl, OpMov, 1'b0, 0, 4, 0, ShLsl, 3), 1'b1, 1'b0, 1'b0);
        waitForWrite();
        idleCycles(2);
    endtask

    task automatic aluChain();
        runCycle(encImm(CondAl, OpMov, 1'b0, 0, 1, 0, 8'hFF), 1'b1, 1'b0, 1'b0);
        runCycle(encImm(CondAl, OpMov, 1'b0, 0, 2, 4, 8'h3F), 1'b1, 1'b0, 1'b0);
        runCycle(encReg(CondAl, OpAdd, 1'b0, 1, 3, 0, ShLsl, 2), 1'b1, 1'b0, 1'b0);
        runCycle(encImm(CondAl, OpSub, 1'b0, 3, 4, 0, 8'h01), 1'b1, 1'b0, 1'b0);
        runCycle(encImm(CondAl, OpRsb, 1'b0, 4, 5, 15, 8'h02), 1'b1, 1'b0, 1'b0);
        runCycle(encReg(CondAl, OpAnd, 1'b0, 5, 6, 0, ShLsl, 4), 1'b1, 1'b0, 1'b0);
        runCycle(encImm(CondAl, OpOrr, 1'b0, 6, 7, 2, 8'hF0), 1'b1, 1'b0, 1'b0);
        runCycle(encReg(CondAl, OpEor, 1'b0, 7, 8, 0, ShLsl, 5), 1'b1, 1'b0, 1'b0);
        runCycle(encReg(CondAl, OpBic, 1'b0, 8, 9, 0, ShLsl, 1), 1'b1, 1'b0, 1'b0);
        idleCycles(2);
    endtask

    task automatic shiftCases();
        runCycle(encImm(CondAl, OpMov, 1'b0, 0, 10, 4, 8'h80), 1'b1, 1'b0, 1'b0);
        runCycle(encImm(CondAl, OpOrr, 1'b0, 10, 10, 0, 8'hF1), 1'b1, 1'b0, 1'b0);
        runCycle(encReg(CondAl, OpMov, 1'b0, 0, 11, 4, ShLsl, 10), 1'b1, 1'b0, 1'b0);
        runCycle(encReg(CondAl, OpMov, 1'b0, 0, 11, 0, ShLsr, 10), 1'b1, 1'b0, 1'b0);
        runCycle(encReg(CondAl, OpMov, 1'b0, 0, 11, 3, ShLsr, 10), 1'b1, 1'b0, 1'b0);
        runCycle(encReg(CondAl, OpMov, 1'b0, 0, 11, 0, ShAsr, 10), 1'b1, 1'b0, 1'b0);
        runCycle(encReg(CondAl, OpMov, 1'b0, 0, 11, 7, ShAsr, 10), 1'b1, 1'b0, 1'b0);
        runCycle(encReg(CondAl, OpMov, 1'b0, 0, 11, 0, ShRor, 10), 1'b1, 1'b0, 1'b0);
        runCycle(encReg(CondAl, OpMov, 1'b0, 0, 11, 12, ShRor, 10), 1'b1, 1'b0, 1'b0);
        runCycle(encReg(CondAl, OpAdd, 1'b0, 11, 12, 1, ShLsl, 10), 1'b1, 1'b0, 1'b0);
        idleCycles(2);
    endtask

    task automatic flagCases();
        runCycle(encImm(CondAl, OpMov, 1'b0, 0, 1, 0, 8'h01), 1'b1, 1'b0, 1'b0);
        runCycle(encImm(CondAl, OpMov, 1'b0, 0, 2, 0, 8'h02), 1'b1, 1'b0, 1'b0);
        runCycle(encReg(CondAl, OpCmp, 1'b1, 1, 0, 0, ShLsl, 2), 1'b1, 1'b0, 1'b0);
        runCycle(encReg(CondAl, OpCmp, 1'b1, 2, 0, 0, ShLsl, 1), 1'b1, 1'b0, 1'b0);
        runCycle(encReg(CondAl, OpCmp, 1'b1, 1, 0, 0, ShLsl, 1), 1'b1, 1'b0, 1'b0); // Equal
        runCycle(encReg(CondEq, OpAdd, 1'b0, 1, 3, 0, ShLsl, 2), 1'b1, 1'b0, 1'b0);
        runCycle(encReg(CondNe, OpAdd, 1'b0, 1, 4, 0, ShLsl, 2), 1'b1, 1'b0, 1'b0);
        runCycle(encImm(CondAl, OpMov, 1'b0, 0, 5, 4, 8'h80), 1'b1, 1'b0, 1'b0);
        runCycle(encReg(CondAl, OpAdd, 1'b1, 5, 6, 0, ShLsl, 5), 1'b1, 1'b0, 1'b0);
        runCycle(encReg(CondAl, OpAdc, 1'b0, 1, 7, 0, ShLsl, 2), 1'b1, 1'b0, 1'b0);
        runCycle(encImm(CondAl, OpMov, 1'b0, 0, 8, 4, 8'h7F), 1'b1, 1'b0, 1'b0);
        runCycle(encReg(CondAl, OpAdd, 1'b1, 8, 9, 0, ShLsl, 8), 1'b1, 1'b0, 1'b0);
        runCycle(encReg(CondVs, OpAdd, 1'b0, 1, 3, 0, ShLsl, 1), 1'b1, 1'b0, 1'b0);
        runCycle(encImm(CondAl, OpSub, 1'b1, 1, 10, 0, 8'h01), 1'b1, 1'b0, 1'b0);
        runCycle(encReg(CondNe, OpAdd, 1'b0, 1, 4, 0, ShLsl, 2), 1'b1, 1'b0, 1'b0);
        idleCycles(2);
    endtask

    task automatic stallFlushCases();
        wordT held;
        held = encReg(CondAl, OpAdd, 1'b0, 1, 6, 0, ShLsl, 2);
        runCycle(held, 1'b1, 1'b0, 1'b0);
        repeat (3) runCycle(held, 1'b0, 1'b1, 1'b0); // The held word runs on with decode idle
        runCycle(encImm(CondAl, OpCmp, 1'b1, 2, 0, 0, 8'h03), 1'b1, 1'b0, 1'b1);
        runCycle(encImm(CondAl, OpMov, 1'b0, 0, 7, 0, 8'h55), 1'b1, 1'b0, 1'b1);
        idleCycles(2);
        runCycle(encImm(CondAl, OpMov, 1'b0, 0, 7, 0, 8'hAA), 1'b0, 1'b0, 1'b0);
        runCycle(encReg(CondAl, OpMov, 1'b0, 0, 13, 0, ShLsl, 7), 1'b1, 1'b0, 1'b0);
        waitForWrite();
        idleCycles(2);
    endtask

    task automatic randomOps();
        logic [3:0] opList [13];
        wordT rndA;
        wordT rndB;
        condT cond;
        logic [3:0] op;
        opList = '{OpAnd, OpEor, OpSub, OpRsb, OpAdd, OpAdc, OpTst, OpTeq, OpCmp, OpCmn,
                   OpOrr, OpMov, OpBic};
        for (int r = 0; r < 16; r++) begin
            loadRegister(r, $random(seed));
        end
        for (int i = 0; i < 200; i++) begin
            rndA = $random(seed);
            rndB = $random(seed);
            op = opList[rndA[7:0] % 13];
            cond = (rndA[27] || rndA[11:8] == 4'hF) ? CondAl : rndA[11:8];
            if (rndA[12]) begin
                runCycle(encImm(cond, op, rndA[13], rndA[17:14], rndA[21:18], rndB[11:8],
                                rndB[7:0]), 1'b1, 1'b0, 1'b0);
            end else begin
                runCycle(encReg(cond, op, rndA[13], rndA[17:14], rndA[21:18], rndB[12:8],
                                rndB[14:13], rndB[3:0]), 1'b1, 1'b0, 1'b0);
            end
        end
        idleCycles(2);
    endtask

    initial begin
        seed = 79;
        errorCount = 0;
        checkCount = 0;
        Reset = 1'b1;
        Instr = '0;
        InstrValid = 1'b0;
        Stall = 1'b0;
        Flush = 1'b0;
        captured = '0;
        capturedValid = 1'b0;
        modelFlags = '0;
        for (int i = 0; i < 16; i++) begin
            modelRegs[i] = '0;
        end
        repeat (3) @(posedge CLK);
        #1;
        Reset = 1'b0;
        resetBehavior();
        aluChain();
        shiftCases();
        flagCases();
        stallFlushCases();
        randomOps();
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(WatchdogCycles * ClkPeriod);
        $display("Simulation did not finish within %0d clock cycles", WatchdogCycles);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire
